/* files.f */
hdl/lsu_pkg.sv
hdl/lsu_decode.sv
hdl/lsu_execute.sv
hdl/single_port_byte_ram.sv
hdl/lsu_result.sv
hdl/lsu_top.sv
verification/lsu_assert.sv
verification/lsu_tb.sv

/* hdl/lsu_decode.sv */
module lsu_decode (
	input  logic              clk,
	input  logic              reset,
	input  logic              cmd_valid,
	input  lsu_pkg::lsu_cmd_t cmd,
	output logic              req_valid,
	output lsu_pkg::mem_req_t req
);

	import lsu_pkg::*;

	logic [XLEN-1:0] offset_ext;
	logic [XLEN-1:0] eff_addr;
	logic            misaligned;

	// sign extend the 12 bit immediate
	assign offset_ext = {{(XLEN-12){cmd.offset[11]}}, cmd.offset};
	assign eff_addr   = cmd.base + offset_ext;

	// alignment depends only on the access width
	always_comb begin
		case (cmd.funct3[1:0])
			F3_H[1:0]: begin
				misaligned = eff_addr[0];
			end
			F3_W[1:0]: begin
				misaligned = |eff_addr[1:0];
			end
			default: begin
				misaligned = 1'b0;	// bytes are always aligned
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			req_valid <= 1'b0;
		end else begin
			req_valid <= cmd_valid;
		end
	end

	// payload follows the valid bit
	always_ff @(posedge clk) begin
		req <= '{
			store:      cmd.store,
			funct3:     cmd.funct3,
			addr:       eff_addr,
			wdata:      cmd.wdata,
			rd:         cmd.rd,
			misaligned: misaligned
		};
	end

endmodule

/* hdl/lsu_execute.sv */
module lsu_execute #(
	parameter int unsigned MEM_WORDS = 1024
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           req_valid,
	input  lsu_pkg::mem_req_t              req,
	output logic                           we,
	output logic [lsu_pkg::BYTES-1:0]      byteenable,
	output logic [$clog2(MEM_WORDS)-1:0]   addr,
	output logic [lsu_pkg::XLEN-1:0]       din,
	output logic                           pend_valid,
	output lsu_pkg::mem_req_t              pend
);

	import lsu_pkg::*;

	localparam int unsigned ADDR_W = $clog2(MEM_WORDS);

	logic [1:0]       lane;
	logic [BYTES-1:0] lane_mask;

	assign lane = req.addr[1:0];

	// one, two or four lanes starting at the byte offset
	always_comb begin
		case (req.funct3[1:0])
			F3_B[1:0]: begin
				lane_mask = BYTES'(1) << lane;
			end
			F3_H[1:0]: begin
				lane_mask = BYTES'(3) << lane;
			end
			default: begin
				lane_mask = '1;
			end
		endcase
	end

	// misaligned stores are dropped here
	assign we         = req_valid & req.store & ~req.misaligned;
	assign byteenable = we ? lane_mask : '0;
	assign din        = req.wdata << {lane, 3'b000};	// move store data onto its lanes
	assign addr       = req.addr[ADDR_W+1:2];	// word address

	// hold the request while the RAM read is in flight
	always_ff @(posedge clk) begin
		if (reset) begin
			pend_valid <= 1'b0;
		end else begin
			pend_valid <= req_valid;
		end
	end

	always_ff @(posedge clk) begin
		pend <= req;
	end

endmodule

/* hdl/lsu_pkg.sv */
package lsu_pkg;

	localparam int unsigned XLEN  = 32;
	localparam int unsigned BYTES = XLEN / 8;	// byte lanes per word

	// funct3 load/store codes
	// bit 2 set means zero extension on loads
	localparam logic [2:0] F3_B  = 3'b000;
	localparam logic [2:0] F3_H  = 3'b001;
	localparam logic [2:0] F3_W  = 3'b010;
	localparam logic [2:0] F3_BU = 3'b100;
	localparam logic [2:0] F3_HU = 3'b101;

	// command as issued by the core
	typedef struct packed {
		logic            store;
		logic [2:0]      funct3;
		logic [XLEN-1:0] base;
		logic [11:0]     offset;	// signed immediate
		logic [XLEN-1:0] wdata;
		logic [4:0]      rd;
	} lsu_cmd_t;

	// decoded request with effective byte address
	typedef struct packed {
		logic            store;
		logic [2:0]      funct3;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
		logic [4:0]      rd;
		logic            misaligned;
	} mem_req_t;

	// one response per command
	typedef struct packed {
		logic [4:0]      rd;
		logic [XLEN-1:0] rdata;
		logic            misaligned;
		logic            store;
	} lsu_rsp_t;

endpackage

/* hdl/lsu_result.sv */
module lsu_result (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     pend_valid,
	input  lsu_pkg::mem_req_t        pend,
	input  logic [lsu_pkg::XLEN-1:0] dout,
	output logic                     rsp_valid,
	output lsu_pkg::lsu_rsp_t        rsp
);

	import lsu_pkg::*;

	logic [XLEN-1:0] shifted;
	logic [XLEN-1:0] load_data;
	logic            zext;

	// addressed byte or halfword down to lane 0
	assign shifted = dout >> {pend.addr[1:0], 3'b000};
	assign zext    = pend.funct3[2];

	always_comb begin
		case (pend.funct3[1:0])
			F3_B[1:0]: begin
				load_data = {{(XLEN-8){~zext & shifted[7]}}, shifted[7:0]};
			end
			F3_H[1:0]: begin
				load_data = {{(XLEN-16){~zext & shifted[15]}}, shifted[15:0]};
			end
			default: begin
				load_data = shifted;
			end
		endcase

		// stores and misaligned loads return zero
		if (pend.store || pend.misaligned) begin
			load_data = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= pend_valid;
		end
	end

	always_ff @(posedge clk) begin
		rsp <= '{
			rd:         pend.rd,
			rdata:      load_data,
			misaligned: pend.misaligned,
			store:      pend.store
		};
	end

endmodule

/* hdl/lsu_top.sv */
module lsu_top #(
	parameter int unsigned MEM_WORDS = 1024
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              cmd_valid,
	input  lsu_pkg::lsu_cmd_t cmd,
	output logic              rsp_valid,
	output lsu_pkg::lsu_rsp_t rsp
);

	import lsu_pkg::*;

	localparam int unsigned ADDR_W = $clog2(MEM_WORDS);

	logic              req_valid;
	mem_req_t          req;
	logic              we;
	logic [BYTES-1:0]  byteenable;
	logic [ADDR_W-1:0] addr;
	logic [XLEN-1:0]   din;
	logic [XLEN-1:0]   dout;
	logic              pend_valid;
	mem_req_t          pend;

	lsu_decode u_decode (
		.clk        ( clk        ),
		.reset      ( reset      ),
		.cmd_valid  ( cmd_valid  ),
		.cmd        ( cmd        ),
		.req_valid  ( req_valid  ),
		.req        ( req        )
	);

	lsu_execute #(
		.MEM_WORDS  ( MEM_WORDS  )
	) u_execute (
		.clk        ( clk        ),
		.reset      ( reset      ),
		.req_valid  ( req_valid  ),
		.req        ( req        ),
		.we         ( we         ),
		.byteenable ( byteenable ),
		.addr       ( addr       ),
		.din        ( din        ),
		.pend_valid ( pend_valid ),
		.pend       ( pend       )
	);

	// data memory
	single_port_byte_ram #(
		.MEM_WORDS  ( MEM_WORDS  )
	) u_ram (
		.clk        ( clk        ),
		.reset      ( reset      ),
		.we         ( we         ),
		.byteenable ( byteenable ),
		.addr       ( addr       ),
		.din        ( din        ),
		.dout       ( dout       )
	);

	lsu_result u_result (
		.clk        ( clk        ),
		.reset      ( reset      ),
		.pend_valid ( pend_valid ),
		.pend       ( pend       ),
		.dout       ( dout       ),
		.rsp_valid  ( rsp_valid  ),
		.rsp        ( rsp        )
	);

endmodule

/* hdl/single_port_byte_ram.sv */
module single_port_byte_ram #(
	parameter int unsigned MEM_WORDS = 1024
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         we,
	input  logic [lsu_pkg::BYTES-1:0]    byteenable,
	input  logic [$clog2(MEM_WORDS)-1:0] addr,
	input  logic [lsu_pkg::XLEN-1:0]     din,
	output logic [lsu_pkg::XLEN-1:0]     dout
);

	import lsu_pkg::*;

	// one byte wide array per lane
	for (genvar i = 0; i < BYTES; i++) begin : gen_lane
		logic [7:0] mem [MEM_WORDS];
		logic [7:0] q;
		logic       lane_we;

		assign lane_we = we & byteenable[i];
		assign dout[i*8 +: 8] = q;

		always_ff @(posedge clk) begin
			if (lane_we) begin
				mem[addr] <= din[i*8 +: 8];
			end
		end

		// read port
		always_ff @(posedge clk) begin
			if (reset) begin
				q <= 8'h00;
			end else if (lane_we) begin
				q <= din[i*8 +: 8];	// write-first
			end else begin
				q <= mem[addr];
			end
		end
	end

endmodule

/* verification/lsu_assert.sv */
module lsu_assert (
	input logic       clk,
	input logic       reset,
	input logic       req_valid,
	input logic       rsp_valid,
	input logic       we,
	input logic [2:0] funct3,
	input logic [1:0] lane,
	input logic [3:0] byteenable
);

	timeunit 1ns;
	timeprecision 1ps;

	logic       misaligned;
	logic [2:0] lane_count;

	// alignment from access width and byte offset
	assign misaligned = (funct3[1:0] == 2'b01 && lane[0]) ||
		(funct3[1:0] == 2'b10 && lane != 2'b00);

	always_comb begin
		case (funct3[1:0])
			2'b00:   lane_count = 3'd1;
			2'b01:   lane_count = 3'd2;
			default: lane_count = 3'd4;	// word
		endcase
	end

	// decode register, then RAM/pend register, then result register
	rsp_follows_req: assert property (@(posedge clk) disable iff (reset)
		rsp_valid == $past(req_valid, 2))
		else $error("rsp_valid does not follow req_valid by two cycles");

	no_misaligned_write: assert property (@(posedge clk) disable iff (reset)
		!(we && misaligned))
		else $error("write enable raised for a misaligned request");

	lanes_on_write: assert property (@(posedge clk) disable iff (reset)
		we |-> $countones(byteenable) == lane_count)
		else $error("write enable raised without the lanes of the access width");

endmodule

bind lsu_top lsu_assert u_assert (
	.clk        ( clk            ),
	.reset      ( reset          ),
	.req_valid  ( req_valid      ),
	.rsp_valid  ( rsp_valid      ),
	.we         ( we             ),
	.funct3     ( req.funct3     ),
	.lane       ( req.addr[1:0]  ),
	.byteenable ( byteenable     )
);

/* verification/lsu_tb.sv */
module lsu_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import lsu_pkg::*;

	localparam int MEM_WORDS      = 1024;
	localparam int MEM_BYTES      = MEM_WORDS * 4;
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int RSP_DELAY      = 4;	// valid 3 edges after the drive edge, seen one edge later

	logic     clk;
	logic     reset;
	logic     cmd_valid;
	lsu_cmd_t cmd;
	logic     rsp_valid;
	lsu_rsp_t rsp;

	logic [7:0]  ref_mem [MEM_BYTES];	// byte model of the data RAM
	lsu_rsp_t    exp_q[$];
	int          issue_q[$];	// cycle of each outstanding command
	int          cycle = 0;
	logic [31:0] lcg_state = 32'hec29;
	string       current_test = "none";

	lsu_top #(
		.MEM_WORDS ( MEM_WORDS )
	) uut (
		.clk       ( clk       ),
		.reset     ( reset     ),
		.cmd_valid ( cmd_valid ),
		.cmd       ( cmd       ),
		.rsp_valid ( rsp_valid ),
		.rsp       ( rsp       )
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	// expected response from the architectural rules, and model update
	function automatic lsu_rsp_t model_access(input lsu_cmd_t c);
		logic [31:0] ea;
		logic [11:0] idx;
		logic [31:0] word;
		int          nbytes;
		lsu_rsp_t    r;
		ea = c.base + {{20{c.offset[11]}}, c.offset};
		idx = ea[11:0];
		nbytes = (c.funct3[1:0] == 2'b00) ? 1 : (c.funct3[1:0] == 2'b01) ? 2 : 4;
		r.rd = c.rd;
		r.store = c.store;
		r.rdata = '0;
		r.misaligned = (nbytes == 2 && ea[0]) || (nbytes == 4 && ea[1:0] != 2'b00);
		if (!r.misaligned) begin
			if (c.store) begin
				for (int i = 0; i < nbytes; i++) begin
					ref_mem[idx + i] = c.wdata[8*i +: 8];
				end
			end else begin
				word = '0;
				for (int i = 0; i < nbytes; i++) begin
					word[8*i +: 8] = ref_mem[idx + i];
				end
				if (!c.funct3[2] && nbytes == 1) word = {{24{word[7]}}, word[7:0]};
				if (!c.funct3[2] && nbytes == 2) word = {{16{word[15]}}, word[15:0]};
				r.rdata = word;
			end
		end
		return r;
	endfunction

	task automatic issue(input logic st, input logic [2:0] f3, input logic [31:0] base,
		input logic [11:0] offset, input logic [31:0] wdata, input logic [4:0] rd);
		lsu_cmd_t c;
		c = '{store: st, funct3: f3, base: base, offset: offset, wdata: wdata, rd: rd};
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd <= c;
		exp_q.push_back(model_access(c));
		issue_q.push_back(cycle);
	endtask

	task automatic drain();
		@(posedge clk);
		cmd_valid <= 1'b0;
		while (exp_q.size() != 0) @(posedge clk);
		repeat (2) @(posedge clk);
	endtask

	// responses in order, one per command
	always @(posedge clk) begin
		if (rsp_valid) begin
			if (exp_q.size() == 0) begin
				$display("A response arrived with no command outstanding in test %s", current_test);
				stop_with_failure();
			end else begin
				check(current_test, exp_q[0], rsp);
				check({current_test, " latency"}, RSP_DELAY, cycle - issue_q[0]);
				void'(exp_q.pop_front());
				void'(issue_q.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	task automatic test_reset();
		current_test = "reset";
		@(posedge clk);	// outputs still unknown before the first edge
		repeat (7) begin
			@(posedge clk);
			check(current_test, 64'(0), 64'(rsp_valid));
		end
		reset <= 1'b0;
		repeat (10) begin
			@(posedge clk);
			check(current_test, 64'(0), 64'(rsp_valid));
		end
	endtask

	task automatic test_words();
		current_test = "words";
		issue(1'b1, F3_W, 32'h100, 12'h000, 32'hdead_beef, 5'd3);
		issue(1'b0, F3_W, 32'h100, 12'h000, 32'h0, 5'd4);
		issue(1'b1, F3_W, 32'h120, 12'hffc, 32'h1234_5678, 5'd5);	// -4
		issue(1'b0, F3_W, 32'h110, 12'h00c, 32'h0, 5'd6);
		drain();
	endtask

	task automatic test_bytes();
		current_test = "bytes";
		issue(1'b1, F3_W, 32'h200, 12'h0, 32'h8070_6050, 5'd1);
		for (int i = 0; i < 4; i++) begin
			issue(1'b1, F3_B, 32'h200 + i, 12'h0, {24'hc0ffee, 8'(8'h71 + i * 8'h22)}, 5'd2);
			issue(1'b0, F3_W, 32'h200, 12'h0, 32'h0, 5'd3);
		end
		issue(1'b1, F3_W, 32'h204, 12'h0, 32'h1122_3344, 5'd1);
		issue(1'b1, F3_H, 32'h204, 12'h0, 32'hffff_7abc, 5'd2);
		issue(1'b0, F3_W, 32'h204, 12'h0, 32'h0, 5'd3);
		issue(1'b1, F3_H, 32'h206, 12'h0, 32'h0000_9def, 5'd2);
		issue(1'b0, F3_W, 32'h204, 12'h0, 32'h0, 5'd3);
		for (int i = 0; i < 4; i++) begin
			issue(1'b0, F3_B, 32'h200 + i, 12'h0, 32'h0, 5'd7);
			issue(1'b0, F3_BU, 32'h200 + i, 12'h0, 32'h0, 5'd8);
		end
		for (int i = 0; i < 4; i += 2) begin
			issue(1'b0, F3_H, 32'h204 + i, 12'h0, 32'h0, 5'd9);
			issue(1'b0, F3_HU, 32'h204 + i, 12'h0, 32'h0, 5'd10);
		end
		drain();
	endtask

	task automatic test_misaligned();
		current_test = "misaligned";
		issue(1'b1, F3_W, 32'h300, 12'h0, 32'ha1b2_c3d4, 5'd1);
		issue(1'b1, F3_H, 32'h301, 12'h0, 32'h5555_5555, 5'd2);
		issue(1'b1, F3_W, 32'h302, 12'h0, 32'h6666_6666, 5'd3);
		issue(1'b1, F3_W, 32'h301, 12'h0, 32'h7777_7777, 5'd4);
		issue(1'b0, F3_W, 32'h303, 12'h0, 32'h0, 5'd5);
		issue(1'b0, F3_H, 32'h301, 12'h0, 32'h0, 5'd6);
		issue(1'b0, F3_W, 32'h300, 12'h0, 32'h0, 5'd7);	// memory must be unchanged
		drain();
	endtask

	function automatic logic [2:0] pick_funct3(input logic st, input logic [2:0] sel);
		if (st) return (sel[1:0] == 2'd0) ? F3_B : (sel[1:0] == 2'd1) ? F3_H : F3_W;
		case (sel % 5)
			0: return F3_B;
			1: return F3_H;
			2: return F3_W;
			3: return F3_BU;
			default: return F3_HU;
		endcase
	endfunction

	task automatic test_random();
		logic [31:0] r;
		logic [31:0] target;
		logic [11:0] off;
		logic [2:0]  f3;
		current_test = "random";
		for (int w = 0; w < 16; w++) begin
			target = 32'h400 + 4 * w;
			issue(1'b1, F3_W, target, 12'h0, (target * 32'h0101_0101) ^ 32'h5a3c_96e1, 5'd0);
		end
		for (int i = 0; i < 200; i++) begin
			r = next_rand();
			f3 = pick_funct3(r[31], r[4:2]);
			target = 32'h400 + r[21:16];	// 16 word window
			if (r[23:22] != 2'b00 && f3[1:0] == 2'b01) target[0] = 1'b0;
			if (r[23:22] != 2'b00 && f3[1:0] == 2'b10) target[1:0] = 2'b00;
			off = {1'b1, r[14:4]};	// always negative
			issue(r[31], f3, target - {{20{off[11]}}, off}, off, next_rand(), 5'(i));
		end
		drain();
	endtask

	initial begin
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		test_reset();
		test_words();
		test_bytes();
		test_misaligned();
		test_random();
		if (exp_q.size() == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("%0d responses never arrived", exp_q.size());
			stop_with_failure();
		end
	end

endmodule
